/* ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Width of one datapath slice.
// Every instruction walks the word one slice per cycle.
`define EX_SLICE_W 4

// Width of an architectural register.
`define EX_WORD_W 16

// Number of general registers.
// Register 0 is hard-wired to zero.
`define EX_NUM_REGS 16

// Number of slices that make up one word.
// This also sets the width of the slice counter.
`define EX_NSLICES 4

// Width of the conditional-execution mask.
// Bit 0 is the polarity of the next instruction and the upper bits mark the
// run of instructions still under the mask.
`define EX_COND_W 8

`endif

/* ex_pkg.sv */
`include "ex_config.svh"

package ex_pkg;

  // One slice of a register, as processed in a single cycle.
  typedef logic [`EX_SLICE_W-1:0] slice_t;

  // A full architectural register value.
  typedef logic [`EX_WORD_W-1:0] word_t;

  // Register index, wide enough for the whole register file.
  typedef logic [$clog2(`EX_NUM_REGS)-1:0] reg_t;

  // Slice counter, which wraps after the last slice of a word.
  typedef logic [$clog2(`EX_NSLICES)-1:0] ctr_t;

  // Conditional-execution mask.
  typedef logic [`EX_COND_W-1:0] cond_t;

  // Operations understood by the execute core.
  // ADDI takes its immediate from the rhs field and the compares only write
  // the predicate.
  typedef enum logic [3:0] {
    NOP    = 4'h0,
    ADD    = 4'h1,
    SUB    = 4'h2,
    AND    = 4'h3,
    OR     = 4'h4,
    XOR    = 4'h5,
    ADDI   = 4'h6,
    CMPEQ  = 4'h7,
    CMPLT  = 4'h8,
    CMPLTU = 4'h9,
    COND   = 4'ha,
    OUT    = 4'hb
  } opcode_t;

  // Instruction word as it arrives from outside.
  // For COND the dst and lhs fields together hold the new mask.
  typedef struct packed {
    opcode_t opcode;
    reg_t    dst;
    reg_t    lhs;
    reg_t    rhs;
  } instr_t;

endpackage

/* ex_slice_if.sv */
`timescale 1ns/1ps

// Per-slice control, produced by the sequencer and consumed by the register
// file and the ALU.
interface ex_slice_if;

  // Index of the slice being worked on this cycle.
  ex_pkg::ctr_t    ctr;

  // High when the current slice completes at the next edge.
  logic            step;

  // Operation of the held instruction.
  ex_pkg::opcode_t op;

  // High when an instruction is held and the condition mask lets it execute.
  logic            run;

  // Register operands of the held instruction.
  ex_pkg::reg_t    dst_reg;
  ex_pkg::reg_t    lhs_reg;
  ex_pkg::reg_t    rhs_reg;

  // Raw rhs field, used as the ADDI immediate.
  ex_pkg::slice_t  imm;

  // The sequencer owns every signal.
  modport seq (output ctr, step, op, run, dst_reg, lhs_reg, rhs_reg, imm);

  // The register file needs addressing and the write qualifiers.
  modport rf (input ctr, step, op, run, dst_reg, lhs_reg, rhs_reg);

  // The ALU needs the operation, the slice position and the immediate.
  modport alu (input ctr, step, op, run, imm);

endinterface

/* ex_sequencer.sv */
`timescale 1ns/1ps

`include "ex_config.svh"

// Instruction sequencer.
// Holds one instruction, walks its slices and applies the condition mask.
module ex_sequencer (
  // Clock and reset.
  input  var logic           i_ex_gck,
  input  var logic           i_ex_rst_n,

  // Instruction input handshake.
  input  var ex_pkg::instr_t i_instr,
  input  var logic           i_instr_vld,
  output var logic           o_instr_acp,

  // Predicate from the ALU.
  input  var logic           i_pred,

  // UART transmit handshake. The data itself comes from the ALU.
  output var logic           o_tx_vld,
  input  var logic           i_tx_acp,

  // Slice control towards the register file and the ALU.
  ex_slice_if.seq            slice_if
);

  // Index of the final slice of a word.
  localparam ex_pkg::ctr_t CTR_LAST = ex_pkg::ctr_t'(`EX_NSLICES - 1);

  // Held instruction and whether it is valid.
  ex_pkg::instr_t instr_q;
  logic           busy_q;

  // Current slice.
  ex_pkg::ctr_t   ctr_q;

  // Condition mask and the skip decision it produces.
  ex_pkg::cond_t  cond_q;
  logic           cond_active;
  logic           skip;

  // Slice progress.
  logic           run;
  logic           step;
  logic           last;

  // The mask only governs execution while some bit above bit 0 is set.
  always_comb cond_active = |cond_q[`EX_COND_W-1:1];

  // Bit 0 says which predicate value lets the instruction run, so a mismatch
  // means skip.
  always_comb skip = cond_active && (cond_q[0] ? !i_pred : i_pred);

  // An instruction runs when one is held and it is not skipped.
  always_comb run = busy_q && !skip;

  // Transmit valid is raised only for an OUT that actually executes.
  always_comb o_tx_vld = run && instr_q.opcode == ex_pkg::OUT;

  // A running OUT moves on only when the UART takes the slice; all other
  // instructions, skipped ones included, never stall.
  always_comb step = busy_q && (!o_tx_vld || i_tx_acp);

  // Completion of the final slice ends the instruction.
  always_comb last = step && ctr_q == CTR_LAST;

  // A new word can be taken when idle or as the held one finishes, which
  // keeps back-to-back instructions free of bubbles.
  always_comb o_instr_acp = !busy_q || last;

  // The held word is payload and only moves on a transfer.
  always_ff @(posedge i_ex_gck) begin
    if (i_instr_vld && o_instr_acp) begin
      instr_q <= i_instr;
    end
  end

  // Busy flag and slice counter.
  // The counter wraps back to zero on the last slice.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      busy_q <= 1'b0;
      ctr_q  <= '0;
    end
    else begin
      if (i_instr_vld && o_instr_acp) begin
        busy_q <= 1'b1;
      end
      else if (last) begin
        busy_q <= 1'b0;
      end

      if (step) begin
        ctr_q <= ctr_q + ex_pkg::ctr_t'(1);
      end
    end
  end

  // A COND that executes loads a fresh mask from its dst and lhs fields.
  // Every other instruction consumes one mask position on completion.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      cond_q <= '0;
    end
    else if (last) begin
      if (run && instr_q.opcode == ex_pkg::COND) begin
        cond_q <= ex_pkg::cond_t'({instr_q.dst, instr_q.lhs});
      end
      else begin
        cond_q <= cond_q >> 1;
      end
    end
  end

  // Drive the slice control bundle.
  always_comb slice_if.ctr     = ctr_q;
  always_comb slice_if.step    = step;
  always_comb slice_if.op      = instr_q.opcode;
  always_comb slice_if.run     = run;
  always_comb slice_if.dst_reg = instr_q.dst;
  always_comb slice_if.lhs_reg = instr_q.lhs;
  always_comb slice_if.rhs_reg = instr_q.rhs;
  always_comb slice_if.imm     = ex_pkg::slice_t'(instr_q.rhs);

  // A stalled OUT keeps its slice and its valid until the UART accepts.
  ap_out_stall_hold : assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    o_tx_vld && !i_tx_acp |=> o_tx_vld && ctr_q == $past(ctr_q)
  );

endmodule

/* ex_regfile.sv */
`timescale 1ns/1ps

`include "ex_config.svh"

// Register file.
// Registers are read and written one slice at a time, at the slice that the
// sequencer currently points at.
module ex_regfile (
  // Clock and reset.
  input  var logic           i_ex_gck,
  input  var logic           i_ex_rst_n,

  // Slice control from the sequencer.
  ex_slice_if.rf             slice_if,

  // Write data from the ALU and operand slices back to it.
  input  var ex_pkg::slice_t i_wr_slice,
  output var ex_pkg::slice_t o_lhs_slice,
  output var ex_pkg::slice_t o_rhs_slice
);

  // Register storage.
  ex_pkg::word_t regs [`EX_NUM_REGS];

  // Write qualifiers.
  logic          wr_op;
  logic          wr_en;

  // Current contents of the destination register.
  ex_pkg::word_t dst_word;

  // Only the ALU operations and ADDI produce a register result.
  always_comb begin
    unique case (slice_if.op)
      ex_pkg::ADD, ex_pkg::SUB, ex_pkg::AND,
      ex_pkg::OR, ex_pkg::XOR, ex_pkg::ADDI: wr_op = 1'b1;
      default:                               wr_op = 1'b0;
    endcase
  end

  // Register 0 is never written so that it keeps reading as zero.
  always_comb wr_en = slice_if.step && slice_if.run && wr_op && slice_if.dst_reg != '0;

  // Write the selected slice at the end of its cycle.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      regs <= '{default: '0};
    end
    else if (wr_en) begin
      regs[slice_if.dst_reg][int'(slice_if.ctr) * `EX_SLICE_W +: `EX_SLICE_W] <= i_wr_slice;
    end
  end

  // Read both operand slices, forcing zero for register 0.
  always_comb begin
    o_lhs_slice = regs[slice_if.lhs_reg][int'(slice_if.ctr) * `EX_SLICE_W +: `EX_SLICE_W];
    o_rhs_slice = regs[slice_if.rhs_reg][int'(slice_if.ctr) * `EX_SLICE_W +: `EX_SLICE_W];

    if (slice_if.lhs_reg == '0) begin
      o_lhs_slice = '0;
    end
    if (slice_if.rhs_reg == '0) begin
      o_rhs_slice = '0;
    end
  end

  always_comb dst_word = regs[slice_if.dst_reg];

  // A skipped instruction must leave its destination register untouched.
  ap_no_write_skip : assert property (
    @(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    slice_if.step && !slice_if.run |=> regs[$past(slice_if.dst_reg)] == $past(dst_word)
  );

endmodule

/* ex_alu.sv */
`timescale 1ns/1ps

`include "ex_config.svh"

// Slice ALU.
// Adds, subtracts and does bitwise logic one slice per cycle, carrying the
// carry and zero flag between slices, and owns the predicate register.
module ex_alu (
  // Clock and reset.
  input  var logic           i_ex_gck,
  input  var logic           i_ex_rst_n,

  // Slice control from the sequencer.
  ex_slice_if.alu            slice_if,

  // Operand slices from the register file.
  input  var ex_pkg::slice_t i_lhs_slice,
  input  var ex_pkg::slice_t i_rhs_slice,

  // Result slice, UART transmit slice and the predicate.
  output var ex_pkg::slice_t o_wr_slice,
  output var ex_pkg::slice_t o_tx_data,
  output var logic           o_pred
);

  // Index of the final slice of a word.
  localparam ex_pkg::ctr_t CTR_LAST = ex_pkg::ctr_t'(`EX_NSLICES - 1);

  // Operand selection.
  ex_pkg::slice_t         rhs_raw;
  ex_pkg::slice_t         rhs_op;
  logic                   inv;
  logic                   cin;
  logic                   first;

  // Adder output, with the carry out on top.
  logic [`EX_SLICE_W:0]   sum;

  // Flags. Z covers the whole word, N, C and V are taken from the top slice.
  logic                   carry_q;
  logic                   z_q;
  logic                   flag_z;
  logic                   flag_n;
  logic                   flag_c;
  logic                   flag_v;

  // Predicate state.
  logic                   cmp;
  logic                   pred_wr;
  logic                   pred_q;
  logic                   pred_d;

  always_comb first = slice_if.ctr == '0;

  // The ADDI immediate only fills the bottom slice.
  always_comb rhs_raw = slice_if.op == ex_pkg::ADDI ? (first ? slice_if.imm : '0)
                                                    : i_rhs_slice;

  // Subtraction and compares are lhs + ~rhs + 1.
  always_comb cmp = slice_if.op inside {ex_pkg::CMPEQ, ex_pkg::CMPLT, ex_pkg::CMPLTU};
  always_comb inv = cmp || slice_if.op == ex_pkg::SUB;
  always_comb rhs_op = inv ? ~rhs_raw : rhs_raw;

  // The seed carry enters at slice 0, later slices chain from the saved one.
  always_comb cin = first ? inv : carry_q;

  always_comb sum = {1'b0, i_lhs_slice} + {1'b0, rhs_op} + (`EX_SLICE_W + 1)'(cin);

  // Result selection.
  always_comb begin
    unique case (slice_if.op)
      ex_pkg::AND: o_wr_slice = i_lhs_slice & i_rhs_slice;
      ex_pkg::OR:  o_wr_slice = i_lhs_slice | i_rhs_slice;
      ex_pkg::XOR: o_wr_slice = i_lhs_slice ^ i_rhs_slice;
      default:     o_wr_slice = sum[`EX_SLICE_W-1:0];
    endcase
  end

  // The zero flag keeps folding in each slice so that it covers the word.
  always_comb flag_z = (first || z_q) && sum[`EX_SLICE_W-1:0] == '0;
  always_comb flag_n = sum[`EX_SLICE_W-1];
  always_comb flag_c = sum[`EX_SLICE_W];

  // Overflow when both adder inputs agree in sign and the result does not.
  always_comb flag_v = i_lhs_slice[`EX_SLICE_W-1] == rhs_op[`EX_SLICE_W-1]
                    && sum[`EX_SLICE_W-1] != i_lhs_slice[`EX_SLICE_W-1];

  // Carry and zero only matter inside one instruction.
  always_ff @(posedge i_ex_gck) begin
    if (slice_if.step) begin
      carry_q <= flag_c;
      z_q     <= flag_z;
    end
  end

  // Predicate is written at the end of the final slice of a running compare.
  always_comb pred_wr = slice_if.step && slice_if.run && cmp && slice_if.ctr == CTR_LAST;

  always_comb begin
    unique case (slice_if.op)
      ex_pkg::CMPEQ: pred_d = flag_z;
      ex_pkg::CMPLT: pred_d = flag_n != flag_v;
      default:       pred_d = !flag_c;
    endcase
  end

  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= 1'b0;
    end
    else if (pred_wr) begin
      pred_q <= pred_d;
    end
  end

  always_comb o_pred = pred_q;

  // OUT sends the lhs register unchanged.
  always_comb o_tx_data = i_lhs_slice;

endmodule

/* ex_core.sv */
`timescale 1ns/1ps

// Nibble-serial execute core.
// Top level, holding the sequencer, register file and ALU.
module ex_core (
  // Clock and reset.
  input  var logic           i_ex_gck,
  input  var logic           i_ex_rst_n,

  // Instruction input.
  input  var ex_pkg::word_t  i_instr,
  input  var logic           i_instr_vld,
  output var logic           o_instr_acp,

  // UART transmit.
  output var ex_pkg::slice_t o_tx_data,
  output var logic           o_tx_vld,
  input  var logic           i_tx_acp
);

  // Operand and result slices between the register file and the ALU.
  ex_pkg::slice_t wr_slice;
  ex_pkg::slice_t lhs_slice;
  ex_pkg::slice_t rhs_slice;

  // Predicate fed back for the skip decision.
  logic           pred;

  // Per-slice control.
  ex_slice_if slice_if_u ();

  // Instruction sequencing and condition mask.
  ex_sequencer seq_u (
    .i_ex_gck    (i_ex_gck),
    .i_ex_rst_n  (i_ex_rst_n),

    .i_instr     (ex_pkg::instr_t'(i_instr)),
    .i_instr_vld (i_instr_vld),
    .o_instr_acp (o_instr_acp),

    .i_pred      (pred),

    .o_tx_vld    (o_tx_vld),
    .i_tx_acp    (i_tx_acp),

    .slice_if    (slice_if_u.seq)
  );

  // Register file.
  ex_regfile rf_u (
    .i_ex_gck    (i_ex_gck),
    .i_ex_rst_n  (i_ex_rst_n),

    .slice_if    (slice_if_u.rf),

    .i_wr_slice  (wr_slice),
    .o_lhs_slice (lhs_slice),
    .o_rhs_slice (rhs_slice)
  );

  // Slice ALU.
  ex_alu alu_u (
    .i_ex_gck    (i_ex_gck),
    .i_ex_rst_n  (i_ex_rst_n),

    .slice_if    (slice_if_u.alu),

    .i_lhs_slice (lhs_slice),
    .i_rhs_slice (rhs_slice),

    .o_wr_slice  (wr_slice),
    .o_tx_data   (o_tx_data),
    .o_pred      (pred)
  );

endmodule

/* tb_ex_core.sv */
`timescale 1ns/1ps

`include "ex_config.svh"

module tb_ex_core;

  // Longest run of cycles a single slice can wait for the UART accept.
  localparam int STALL_MAX = 4;

  // DUT connections.
  logic        ex_gck;
  logic        ex_rst_n;
  logic [15:0] instr;
  logic        instr_vld;
  logic        instr_acp;
  logic [`EX_SLICE_W-1:0] tx_data;
  logic        tx_vld;
  logic        tx_acp;

  // Program and the words the model expects OUT to deliver.
  logic [15:0] prog [$];
  logic [15:0] exp_q [$];
  string       name_q [$];
  int          exp_total;
  int          stall_start;
  logic        stall_en;

  // Reference model state.
  logic [15:0] m_regs [16];
  logic        m_pred;
  logic [7:0]  m_mask;

  // Receive side bookkeeping.
  logic [15:0] cur_word;
  int          slice_idx;
  int          slices_got;
  int          words_got;
  int          value_err;
  int          comp_err;
  int          seq_err;

  ex_core i_ex_core (
    .i_ex_gck    (ex_gck),
    .i_ex_rst_n  (ex_rst_n),
    .i_instr     (instr),
    .i_instr_vld (instr_vld),
    .o_instr_acp (instr_acp),
    .o_tx_data   (tx_data),
    .o_tx_vld    (tx_vld),
    .i_tx_acp    (tx_acp)
  );

  initial begin
    ex_gck = 1'b0;
    forever #5 ex_gck = ~ex_gck;
  end

  function automatic logic [15:0] make_instr(input ex_pkg::opcode_t op, input logic [3:0] dst,
                                             input logic [3:0] lhs, input logic [3:0] rhs);
    return {op, dst, lhs, rhs};
  endfunction

  // Executes one instruction on the model and returns 1 when it sends a word.
  function automatic logic model_step(input logic [15:0] w, output logic [15:0] out_word);
    ex_pkg::opcode_t op;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic        skip;
    logic        wr;
    logic        sends;
    op = ex_pkg::opcode_t'(w[15:12]);
    a = m_regs[w[7:4]];
    b = m_regs[w[3:0]];
    // A set bit 0 asks for a true predicate, a clear one for a false one.
    skip = (|m_mask[7:1]) && (m_mask[0] != m_pred);
    r = '0;
    wr = 1'b0;
    sends = 1'b0;
    out_word = a;
    if (!skip) begin
      case (op)
        ex_pkg::ADD:    begin r = a + b; wr = 1'b1; end
        ex_pkg::SUB:    begin r = a - b; wr = 1'b1; end
        ex_pkg::AND:    begin r = a & b; wr = 1'b1; end
        ex_pkg::OR:     begin r = a | b; wr = 1'b1; end
        ex_pkg::XOR:    begin r = a ^ b; wr = 1'b1; end
        ex_pkg::ADDI:   begin r = a + {12'd0, w[3:0]}; wr = 1'b1; end
        ex_pkg::CMPEQ:  m_pred = (a == b);
        ex_pkg::CMPLT:  m_pred = ($signed(a) < $signed(b));
        ex_pkg::CMPLTU: m_pred = (a < b);
        ex_pkg::OUT:    sends = 1'b1;
        default:        sends = 1'b0;
      endcase
    end
    if (wr && w[11:8] != 4'd0) begin
      m_regs[w[11:8]] = r;
    end
    if (!skip && op == ex_pkg::COND) begin
      m_mask = w[11:4];
    end
    else begin
      m_mask = m_mask >> 1;
    end
    return sends;
  endfunction

  task automatic add_instr(input logic [15:0] w, input string name);
    logic [15:0] word;
    prog.push_back(w);
    if (model_step(w, word)) begin
      exp_q.push_back(word);
      name_q.push_back(name);
    end
  endtask

  // Builds a 16-bit constant nibble by nibble with ADDI and doubling ADDs.
  task automatic load_reg(input logic [3:0] r, input logic [15:0] value, input string name);
    add_instr(make_instr(ex_pkg::ADDI, r, 4'd0, value[15:12]), name);
    for (int k = 2; k >= 0; k--) begin
      repeat (4) add_instr(make_instr(ex_pkg::ADD, r, r, r), name);
      add_instr(make_instr(ex_pkg::ADDI, r, r, value[k*4 +: 4]), name);
    end
  endtask

  task automatic build_program();
    ex_pkg::opcode_t alu_ops [4];
    ex_pkg::opcode_t cmp_ops [3];
    logic [3:0] d;
    alu_ops = '{ex_pkg::SUB, ex_pkg::AND, ex_pkg::OR, ex_pkg::XOR};
    cmp_ops = '{ex_pkg::CMPEQ, ex_pkg::CMPLT, ex_pkg::CMPLTU};
    foreach (m_regs[i]) m_regs[i] = '0;
    m_pred = 1'b0;
    m_mask = '0;
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd0, 4'd0), "reset_out");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd5, 4'd0), "reset_out");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd15, 4'd0), "reset_out");
    // 15 + 1 carries out of slice 0.
    add_instr(make_instr(ex_pkg::ADDI, 4'd1, 4'd0, 4'd15), "const_build");
    add_instr(make_instr(ex_pkg::ADDI, 4'd1, 4'd1, 4'd1), "const_build");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd1, 4'd0), "const_build");
    load_reg(4'd3, 16'hffff, "const_build");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd3, 4'd0), "const_build");
    // Carry ripples through every slice and wraps to zero.
    add_instr(make_instr(ex_pkg::ADDI, 4'd3, 4'd3, 4'd1), "const_build");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd3, 4'd0), "const_build");
    add_instr(make_instr(ex_pkg::ADD, 4'd2, 4'd1, 4'd1), "const_build");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd2, 4'd0), "const_build");
    for (int r = 1; r < 8; r++) begin
      load_reg(4'(r), 16'($urandom), "rand_load");
      add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'(r), 4'd0), "rand_load");
    end
    for (int n = 0; n < 40; n++) begin
      d = 4'($urandom % 8);
      add_instr(make_instr(alu_ops[2'($urandom)], d, 4'($urandom % 8), 4'($urandom % 8)),
                "rand_alu");
      add_instr(make_instr(ex_pkg::OUT, 4'd0, d, 4'd0), "rand_alu");
    end
    add_instr(make_instr(ex_pkg::XOR, 4'd0, 4'd1, 4'd2), "reg0_write");
    add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'd0, 4'd0), "reg0_write");
    for (int n = 0; n < 30; n++) begin
      add_instr(make_instr(cmp_ops[2'($urandom % 3)], 4'd0, 4'($urandom % 8),
                           4'($urandom % 8)), "cond_mask");
      add_instr(make_instr(ex_pkg::COND, 4'($urandom), 4'($urandom), 4'd0), "cond_mask");
      repeat (3) begin
        add_instr(make_instr(alu_ops[2'($urandom)], 4'(1 + $urandom % 7), 4'($urandom % 8),
                             4'($urandom % 8)), "cond_mask");
        add_instr(make_instr(ex_pkg::OUT, 4'd0, 4'($urandom % 8), 4'd0), "cond_mask");
      end
    end
    // Eight shifts clear whatever mask is left.
    repeat (8) add_instr(make_instr(ex_pkg::NOP, 4'd0, 4'd0, 4'd0), "mask_drain");
    stall_start = prog.size();
    for (int n = 0; n < 30; n++) begin
      d = 4'(1 + $urandom % 7);
      add_instr(make_instr(alu_ops[2'($urandom)], d, 4'($urandom % 8), 4'($urandom % 8)),
                "tx_stall");
      add_instr(make_instr(ex_pkg::OUT, 4'd0, d, 4'd0), "tx_stall");
    end
    exp_total = exp_q.size();
  endtask

  // Holds the word on the bus until the accept is seen before an edge.
  task automatic send_instr(input logic [15:0] w);
    logic done;
    instr = w;
    instr_vld = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge ex_gck);
      done = instr_acp;
      @(posedge ex_gck);
      #1;
    end
    instr_vld = 1'b0;
  endtask

  initial begin
    instr = '0;
    instr_vld = 1'b0;
    ex_rst_n = 1'b0;
    stall_en = 1'b0;
    seq_err = 0;
    void'($urandom(6457));
    build_program();
    repeat (2) @(posedge ex_gck);
    #1;
    ex_rst_n = 1'b1;
    @(negedge ex_gck);
    assert (!tx_vld && instr_acp) else begin
      $display("Handshake wrong after reset: tx valid %b, instruction accept %b",
               tx_vld, instr_acp);
      seq_err++;
    end
    @(posedge ex_gck);
    #1;
    for (int i = 0; i < prog.size(); i++) begin
      if (i == stall_start) begin
        stall_en = 1'b1;
      end
      send_instr(prog[i]);
    end
    while (words_got < exp_total) @(posedge ex_gck);
    // Leave room for any stray slices from an OUT that should have been skipped.
    repeat (20) @(posedge ex_gck);
    assert (slices_got == exp_total * `EX_NSLICES) else begin
      $display("Received %0d slices where %0d were expected", slices_got,
               exp_total * `EX_NSLICES);
      seq_err++;
    end
    $display("Words %0d of %0d, value errors %0d, other errors %0d", words_got, exp_total,
             value_err, comp_err + seq_err);
    if (value_err == 0 && comp_err == 0 && seq_err == 0) begin
      $display("Test completed successfully");
    end
    else begin
      $display("Test failed");
    end
    $finish;
  end

  // UART accept, randomly held low in the stall phase but never for too long.
  initial begin
    int low_run;
    tx_acp = 1'b1;
    low_run = 0;
    forever begin
      @(posedge ex_gck);
      #1;
      if (stall_en && low_run < STALL_MAX - 1 && ($urandom % 2) == 0) begin
        tx_acp = 1'b0;
        low_run++;
      end
      else begin
        tx_acp = 1'b1;
        low_run = 0;
      end
    end
  end

  // Inputs settle 1 ns after the edge, so the handshake is sampled at the falling edge.
  initial begin
    logic [15:0] exp_word;
    string       name;
    cur_word = '0;
    slice_idx = 0;
    slices_got = 0;
    words_got = 0;
    value_err = 0;
    comp_err = 0;
    forever begin
      @(negedge ex_gck);
      if (ex_rst_n && tx_vld && tx_acp) begin
        cur_word[slice_idx*`EX_SLICE_W +: `EX_SLICE_W] = tx_data;
        slices_got++;
        if (slice_idx == `EX_NSLICES - 1) begin
          slice_idx = 0;
          words_got++;
          assert (exp_q.size() != 0) else begin
            $display("Word %h sent when no OUT was expected", cur_word);
            comp_err++;
          end
          if (exp_q.size() != 0) begin
            exp_word = exp_q.pop_front();
            name = name_q.pop_front();
            assert (cur_word == exp_word) else begin
              $display("ERR %s expected %h actual %h", name, exp_word, cur_word);
              value_err++;
            end
          end
        end
        else begin
          slice_idx++;
        end
      end
    end
  end

  // Budget covers every instruction at full stall plus reset and drain.
  initial begin
    longint limit_ns;
    #1;
    limit_ns = (longint'(prog.size()) * `EX_NSLICES * STALL_MAX + 32) * 10 * 2;
    #(limit_ns);
    $display("Timeout: the DUT did not finish the program within %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
ex_pkg.sv
ex_slice_if.sv
ex_sequencer.sv
ex_regfile.sv
ex_alu.sv
ex_core.sv
tb_ex_core.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ex_core -f src.f -o sim_ex_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_ex_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -Fqx "Test completed successfully"; then
  exit 0
else
  exit 1
fi
